// ==== design/cpuPkg.sv ====
package cpuPkg;

	// instruction opcodes, bits 15:12 of the instruction word
	typedef enum logic [3:0] {
		opAdd  = 4'd0,
		opSub  = 4'd1,
		opAnd  = 4'd2,
		opOr   = 4'd3,
		opXor  = 4'd4,
		opMov  = 4'd5,
		opLdi  = 4'd6,
		opLd   = 4'd7,
		opSt   = 4'd8,
		opJz   = 4'd9,
		opHalt = 4'd10
	} opcodeT;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluPass
	} aluFuncT;

	typedef enum logic {
		srcAlu, // y latch
		srcMem // bus master read word
	} writeSrcT;

	localparam logic [2:0] regR0 = 3'd0;
	localparam logic [2:0] regR1 = 3'd1;
	localparam logic [2:0] regR2 = 3'd2;
	localparam logic [2:0] regR3 = 3'd3;
	localparam logic [2:0] regR4 = 3'd4;
	localparam logic [2:0] regLr = 3'd5;
	localparam logic [2:0] regSp = 3'd6;
	localparam logic [2:0] regPc = 3'd7;

	// register select sources
	localparam logic [1:0] oeFromOp0 = 2'd0;
	localparam logic [1:0] oeFromOp1 = 2'd1;
	localparam logic [1:0] oeFromOp2 = 2'd2;
	localparam logic [1:0] oeFromMicro = 2'd3;
	localparam logic loadFromOp0 = 1'b0;
	localparam logic loadFromMicro = 1'b1;

	localparam int opcodeHi = 15;
	localparam int opcodeLo = 12;
	localparam int op0Hi = 11; // destination or store source
	localparam int op0Lo = 9;
	localparam int op1Hi = 8; // first operand or address
	localparam int op1Lo = 6;
	localparam int op2Hi = 5; // second operand
	localparam int op2Lo = 3;

endpackage

// ==== design/regSel.sv ====
module regSel import cpuPkg::*; (
	input logic regOE,
	input logic regLoad,
	input logic [1:0] oeSourceSel,
	input logic loadSourceSel,
	input logic [2:0] uRegOE,
	input logic [2:0] uRegLoad,
	input logic [2:0] op0,
	input logic [2:0] op1,
	input logic [2:0] op2,
	output logic [7:0] regOEs,
	output logic [7:0] regLoads
);

	logic [2:0] oeIdx;
	logic [2:0] loadIdx;

	always_comb begin
		case (oeSourceSel)
			oeFromOp0: oeIdx = op0;
			oeFromOp1: oeIdx = op1;
			oeFromOp2: oeIdx = op2;
			default: oeIdx = uRegOE; // microcode picks the register
		endcase
	end

	assign loadIdx = (loadSourceSel == loadFromMicro) ? uRegLoad : op0;

	// one-hot, all zero when not enabled
	assign regOEs = regOE ? (8'b1 << oeIdx) : 8'b0;
	assign regLoads = regLoad ? (8'b1 << loadIdx) : 8'b0;

endmodule

// ==== design/registerBank.sv ====
module registerBank import cpuPkg::*; #(
	parameter int dataWidth = 16
) (
	input logic clock,
	input logic reset,
	input logic [7:0] regOEs,
	input logic [7:0] regLoads,
	input logic pcInc,
	input writeSrcT writeSrc,
	input logic [dataWidth-1:0] aluY,
	input logic [dataWidth-1:0] memRdata,
	output logic [dataWidth-1:0] busData
);

	logic [dataWidth-1:0] regs [8]; // r0..r4, lr, sp, pc
	logic [dataWidth-1:0] loadData;

	assign loadData = (writeSrc == srcMem) ? memRdata : aluY;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 8; i++) begin
				if (regLoads[i]) begin
					regs[i] <= loadData;
				end
			end
			// a load into pc wins over the increment
			if (pcInc && !regLoads[regPc]) begin
				regs[regPc] <= regs[regPc] + dataWidth'(1);
			end
		end
	end

	// stands in for the tri-state bus
	always_comb begin
		busData = '0;
		for (int i = 0; i < 8; i++) begin
			if (regOEs[i]) begin
				busData = busData | regs[i];
			end
		end
	end

endmodule

// ==== design/alu.sv ====
module alu import cpuPkg::*; #(
	parameter int dataWidth = 16
) (
	input logic clock,
	input logic reset,
	input logic [dataWidth-1:0] busData,
	input logic loadB,
	input logic loadY,
	input aluFuncT aluFunc,
	output logic [dataWidth-1:0] aluY,
	output logic carry,
	output logic zero
);

	logic [dataWidth-1:0] bReg;
	logic [dataWidth:0] result; // msb is carry out or borrow
	logic carryOut;

	always_comb begin
		case (aluFunc)
			aluAdd: result = {1'b0, busData} + {1'b0, bReg};
			aluSub: result = {1'b0, busData} - {1'b0, bReg};
			aluAnd: result = {1'b0, busData & bReg};
			aluOr: result = {1'b0, busData | bReg};
			aluXor: result = {1'b0, busData ^ bReg};
			default: result = {1'b0, busData}; // pass
		endcase
	end

	// subtract reports carry as no borrow
	assign carryOut = (aluFunc == aluSub) ? ~result[dataWidth] : result[dataWidth];

	always_ff @(posedge clock) begin
		if (loadB) begin
			bReg <= busData;
		end
		if (loadY) begin
			aluY <= result[dataWidth-1:0];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			carry <= 1'b0;
			zero <= 1'b0;
		end else if (loadY) begin
			carry <= carryOut;
			zero <= (result[dataWidth-1:0] == '0);
		end
	end

endmodule

// ==== design/busMaster.sv ====
module busMaster #(
	parameter int dataWidth = 16
) (
	input logic clock,
	input logic reset,
	input logic memReq,
	input logic memWe,
	input logic memWdataLoad,
	input logic [dataWidth-1:0] busData,
	input logic [dataWidth-1:0] wbDatI,
	input logic wbAck,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output logic [dataWidth-1:0] wbAdr,
	output logic [dataWidth-1:0] wbDatO,
	output logic memDone,
	output logic [dataWidth-1:0] memRdata
);

	logic active; // idle or in a bus cycle

	assign wbCyc = active;
	assign wbStb = active;

	always_ff @(posedge clock) begin
		if (reset) begin
			active <= 1'b0;
			wbWe <= 1'b0;
			memDone <= 1'b0;
		end else begin
			memDone <= active && wbAck;
			if (active) begin
				if (wbAck) begin
					active <= 1'b0;
					wbWe <= 1'b0;
				end
			end else if (memReq) begin
				wbWe <= memWe;
				active <= !memWe; // a write starts once its data is latched
			end else if (memWdataLoad) begin
				active <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (memReq && !active) begin
			wbAdr <= busData;
		end
		if (memWdataLoad && !active) begin
			wbDatO <= busData;
		end
		if (active && wbAck && !wbWe) begin
			memRdata <= wbDatI; // held until the next read
		end
	end

endmodule

// ==== design/mSeq.sv ====
module mSeq import cpuPkg::*; #(
	parameter int dataWidth = 16
) (
	input logic clock,
	input logic reset,
	input logic memDone,
	input logic [dataWidth-1:0] memRdata,
	input logic carry,
	input logic zero,
	output logic regOE,
	output logic regLoad,
	output logic [1:0] oeSourceSel,
	output logic loadSourceSel,
	output logic [2:0] uRegOE,
	output logic [2:0] uRegLoad,
	output logic [2:0] op0,
	output logic [2:0] op1,
	output logic [2:0] op2,
	output writeSrcT writeSrc,
	output logic pcInc,
	output logic loadB,
	output logic loadY,
	output aluFuncT aluFunc,
	output logic memReq,
	output logic memWe,
	output logic memWdataLoad,
	output logic halted
);

	typedef enum logic [3:0] {
		sFetch,
		sFetchWait,
		sLoadIr,
		sExec,
		sAluY,
		sAluW,
		sLoadWait,
		sStData,
		sStWait,
		sJzY,
		sJzLoad,
		sHalt
	} stateT;

	stateT state;
	stateT nextState;
	logic [15:0] ir;
	opcodeT opcode;

	function automatic aluFuncT aluFor(opcodeT op);
		case (op)
			opAdd: return aluAdd;
			opSub: return aluSub;
			opAnd: return aluAnd;
			opOr: return aluOr;
			opXor: return aluXor;
			default: return aluPass; // mov
		endcase
	endfunction

	assign opcode = opcodeT'(ir[opcodeHi:opcodeLo]);
	assign op0 = ir[op0Hi:op0Lo];
	assign op1 = ir[op1Hi:op1Lo];
	assign op2 = ir[op2Hi:op2Lo];
	assign halted = (state == sHalt);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= sFetch;
			ir <= '0;
		end else begin
			state <= nextState;
			if (state == sLoadIr) begin
				ir <= memRdata[15:0];
			end
		end
	end

	always_comb begin
		nextState = state;
		regOE = 1'b0;
		regLoad = 1'b0;
		oeSourceSel = oeFromOp0;
		loadSourceSel = loadFromOp0;
		uRegOE = regPc; // microcode only ever selects pc
		uRegLoad = regPc;
		writeSrc = srcAlu;
		pcInc = 1'b0;
		loadB = 1'b0;
		loadY = 1'b0;
		aluFunc = aluPass;
		memReq = 1'b0;
		memWe = 1'b0;
		memWdataLoad = 1'b0;
		case (state)
			sFetch: begin
				regOE = 1'b1; // pc onto the bus as address
				oeSourceSel = oeFromMicro;
				memReq = 1'b1;
				nextState = sFetchWait;
			end
			sFetchWait: begin
				if (memDone) begin
					nextState = sLoadIr;
				end
			end
			sLoadIr: begin
				pcInc = 1'b1;
				nextState = sExec;
			end
			sExec: begin
				case (opcode)
					opAdd, opSub, opAnd, opOr, opXor, opMov: begin
						regOE = 1'b1; // b takes op2
						oeSourceSel = oeFromOp2;
						loadB = 1'b1;
						nextState = sAluY;
					end
					opLdi: begin
						regOE = 1'b1; // immediate word sits at pc
						oeSourceSel = oeFromMicro;
						memReq = 1'b1;
						nextState = sLoadWait;
					end
					opLd: begin
						regOE = 1'b1;
						oeSourceSel = oeFromOp1;
						memReq = 1'b1;
						nextState = sLoadWait;
					end
					opSt: begin
						regOE = 1'b1; // address first
						oeSourceSel = oeFromOp1;
						memReq = 1'b1;
						memWe = 1'b1;
						nextState = sStData;
					end
					opJz: nextState = zero ? sJzY : sFetch;
					opHalt: nextState = sHalt;
					default: nextState = sFetch;
				endcase
			end
			sAluY: begin
				regOE = 1'b1;
				oeSourceSel = oeFromOp1;
				loadY = 1'b1;
				aluFunc = aluFor(opcode);
				nextState = sAluW;
			end
			sAluW: begin
				regLoad = 1'b1; // op0 takes y
				nextState = sFetch;
			end
			sLoadWait: begin
				if (memDone) begin
					regLoad = 1'b1;
					writeSrc = srcMem;
					pcInc = (opcode == opLdi); // step over the immediate
					nextState = sFetch;
				end
			end
			sStData: begin
				regOE = 1'b1;
				oeSourceSel = oeFromOp0;
				memWdataLoad = 1'b1;
				nextState = sStWait;
			end
			sStWait: begin
				if (memDone) begin
					nextState = sFetch;
				end
			end
			sJzY: begin
				// the target goes through y since loads only take y or memory
				regOE = 1'b1;
				oeSourceSel = oeFromOp1;
				loadY = 1'b1;
				nextState = sJzLoad;
			end
			sJzLoad: begin
				regLoad = 1'b1;
				loadSourceSel = loadFromMicro;
				nextState = sFetch;
			end
			sHalt: nextState = sHalt; // until reset
			default: nextState = sFetch;
		endcase
	end

endmodule

// ==== design/cpu.sv ====
module cpu import cpuPkg::*; #(
	parameter int dataWidth = 16
) (
	input logic clock,
	input logic reset,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output logic [dataWidth-1:0] wbAdr,
	output logic [dataWidth-1:0] wbDatO,
	input logic [dataWidth-1:0] wbDatI,
	input logic wbAck,
	output logic halted
);

	logic [dataWidth-1:0] busData;
	logic [dataWidth-1:0] aluY;
	logic [dataWidth-1:0] memRdata;

	// register select, mSeq to regSel
	logic regOE;
	logic regLoad;
	logic [1:0] oeSourceSel;
	logic loadSourceSel;
	logic [2:0] uRegOE;
	logic [2:0] uRegLoad;
	logic [2:0] op0;
	logic [2:0] op1;
	logic [2:0] op2;
	logic [7:0] regOEs; // regSel to registerBank
	logic [7:0] regLoads;

	writeSrcT writeSrc;
	logic pcInc;
	logic loadB;
	logic loadY;
	aluFuncT aluFunc;
	logic carry;
	logic zero;
	logic memReq;
	logic memWe;
	logic memWdataLoad;
	logic memDone;

	mSeq #(.dataWidth(dataWidth)) i_mSeq (
		.clock(clock), .reset(reset), .memDone(memDone), .memRdata(memRdata),
		.carry(carry), .zero(zero), .regOE(regOE), .regLoad(regLoad),
		.oeSourceSel(oeSourceSel), .loadSourceSel(loadSourceSel),
		.uRegOE(uRegOE), .uRegLoad(uRegLoad), .op0(op0), .op1(op1), .op2(op2),
		.writeSrc(writeSrc), .pcInc(pcInc), .loadB(loadB), .loadY(loadY),
		.aluFunc(aluFunc), .memReq(memReq), .memWe(memWe),
		.memWdataLoad(memWdataLoad), .halted(halted)
	);

	regSel i_regSel (
		.regOE(regOE), .regLoad(regLoad), .oeSourceSel(oeSourceSel),
		.loadSourceSel(loadSourceSel), .uRegOE(uRegOE), .uRegLoad(uRegLoad),
		.op0(op0), .op1(op1), .op2(op2), .regOEs(regOEs), .regLoads(regLoads)
	);

	registerBank #(.dataWidth(dataWidth)) i_registerBank (
		.clock(clock), .reset(reset), .regOEs(regOEs), .regLoads(regLoads),
		.pcInc(pcInc), .writeSrc(writeSrc), .aluY(aluY), .memRdata(memRdata),
		.busData(busData)
	);

	alu #(.dataWidth(dataWidth)) i_alu (
		.clock(clock), .reset(reset), .busData(busData), .loadB(loadB),
		.loadY(loadY), .aluFunc(aluFunc), .aluY(aluY), .carry(carry), .zero(zero)
	);

	busMaster #(.dataWidth(dataWidth)) i_busMaster (
		.clock(clock), .reset(reset), .memReq(memReq), .memWe(memWe),
		.memWdataLoad(memWdataLoad), .busData(busData), .wbDatI(wbDatI),
		.wbAck(wbAck), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatO(wbDatO), .memDone(memDone), .memRdata(memRdata)
	);

endmodule

// ==== bench/wbMemory.sv ====
module wbMemory #(
	parameter int dataWidth = 16,
	parameter int addrBits = 8,
	parameter int maxWait = 3,
	parameter int seedInit = 32'h6f147f2c
) (
	input logic clock,
	input logic reset,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [dataWidth-1:0] wbAdr,
	input logic [dataWidth-1:0] wbDatO,
	output logic [dataWidth-1:0] wbDatI,
	output logic wbAck,
	output logic writeSeen,
	output logic [dataWidth-1:0] writeAddr,
	output logic [dataWidth-1:0] writeData
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [dataWidth-1:0] mem [2**addrBits];
	integer seed;
	int waitLeft;
	logic busy; // wait count drawn for the current cycle

	initial begin
		seed = seedInit;
		busy = 1'b0;
		waitLeft = 0;
		wbAck = 1'b0;
		wbDatI = '0;
		writeSeen = 1'b0;
		writeAddr = '0;
		writeData = '0;
		for (int i = 0; i < 2**addrBits; i++) begin
			mem[addrBits'(i)] = dataWidth'(i) ^ dataWidth'('hc3a5); // unused words decode as no-ops
		end
	end

	always @(posedge clock) begin
		#2; // outputs move just after the edge
		writeSeen = 1'b0;
		if (reset || wbAck) begin
			wbAck = 1'b0; // master drops cyc on the edge that saw ack
			busy = 1'b0;
		end else if (wbCyc && wbStb) begin
			if (!busy) begin
				busy = 1'b1;
				waitLeft = $unsigned($random(seed)) % (maxWait + 1);
			end
			if (waitLeft > 0) begin
				waitLeft--;
			end else begin
				wbAck = 1'b1;
				if (wbWe) begin
					mem[wbAdr[addrBits-1:0]] = wbDatO;
					writeSeen = 1'b1; // one-cycle report to the bench
					writeAddr = wbAdr;
					writeData = wbDatO;
				end else begin
					wbDatI = mem[wbAdr[addrBits-1:0]];
				end
			end
		end
	end

endmodule

// ==== bench/cpuBench.sv ====
module cpuBench import cpuPkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int dataWidth = 16;
	localparam int maxWait = 3;
	localparam int seedValue = 32'h6f147f2c;
	localparam int cycleLimit = 400 * (maxWait + 8); // program stays under 100 words

	logic clock = 1'b0;
	logic reset;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [dataWidth-1:0] wbAdr;
	logic [dataWidth-1:0] wbDatO;
	logic [dataWidth-1:0] wbDatI;
	logic wbAck;
	logic halted;
	logic writeSeen;
	logic [dataWidth-1:0] writeAddr;
	logic [dataWidth-1:0] writeData;

	logic [15:0] prog [$];
	logic [15:0] expAddr [$]; // expected store log in order
	logic [15:0] expData [$];
	logic [15:0] presetAddr;
	logic [15:0] presetData;
	integer seed;
	int writeCount = 0;
	int cycleCount = 0;
	logic prevStb = 1'b0;
	logic prevAck = 1'b0;
	logic prevWe = 1'b0;
	logic prevHalted = 1'b0;
	logic [15:0] prevAdr = '0;
	logic [15:0] prevDat = '0;

	cpu #(.dataWidth(dataWidth)) i_dut (
		.clock(clock), .reset(reset), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
		.wbAdr(wbAdr), .wbDatO(wbDatO), .wbDatI(wbDatI), .wbAck(wbAck), .halted(halted)
	);

	wbMemory #(.dataWidth(dataWidth), .maxWait(maxWait), .seedInit(seedValue)) i_mem (
		.clock(clock), .reset(reset), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
		.wbAdr(wbAdr), .wbDatO(wbDatO), .wbDatI(wbDatI), .wbAck(wbAck),
		.writeSeen(writeSeen), .writeAddr(writeAddr), .writeData(writeData)
	);

	always #20 clock = ~clock;

	function automatic logic [15:0] encode(input opcodeT op, input logic [2:0] d,
			input logic [2:0] s1, input logic [2:0] s2);
		logic [15:0] word;
		word = '0;
		word[opcodeHi:opcodeLo] = op;
		word[op0Hi:op0Lo] = d;
		word[op1Hi:op1Lo] = s1;
		word[op2Hi:op2Lo] = s2;
		return word;
	endfunction

	// first operand combined with the second
	function automatic logic [15:0] aluModel(input opcodeT op, input logic [15:0] a,
			input logic [15:0] b);
		case (op)
			opAdd: return a + b;
			opSub: return a - b;
			opAnd: return a & b;
			opOr: return a | b;
			opXor: return a ^ b;
			default: return a; // mov copies the first operand
		endcase
	endfunction

	task automatic reportFailure(input string msg);
		$display("[FAIL] %0t ns %s", $time, msg);
		$display("Checks failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic emitLdi(input logic [2:0] r, input logic [15:0] value);
		prog.push_back(encode(opLdi, r, regR0, regR0));
		prog.push_back(value);
	endtask

	task automatic expectWrite(input logic [15:0] addr, input logic [15:0] data);
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	task automatic addAluTest(input opcodeT op, input logic [15:0] addr);
		logic [15:0] a;
		logic [15:0] b;
		a = 16'($random(seed));
		b = 16'($random(seed));
		emitLdi(regR1, a);
		emitLdi(regR2, b);
		prog.push_back(encode(op, regR3, regR1, regR2));
		emitLdi(regR4, addr);
		prog.push_back(encode(opSt, regR3, regR4, regR0));
		expectWrite(addr, aluModel(op, a, b));
	endtask

	task automatic addJzTest(input logic [15:0] a, input logic [15:0] b,
			input logic [15:0] addr);
		emitLdi(regR1, a);
		emitLdi(regR2, b);
		emitLdi(regR4, addr);
		emitLdi(regLr, 16'(prog.size() + 5)); // word after the store
		prog.push_back(encode(opSub, regR3, regR1, regR2));
		prog.push_back(encode(opJz, regR0, regLr, regR0));
		prog.push_back(encode(opSt, regR1, regR4, regR0));
		if (a != b) begin
			expectWrite(addr, a); // no jump so the store runs
		end
	endtask

	task automatic buildProgram();
		logic [15:0] value;
		value = 16'($random(seed));
		emitLdi(regR1, value);
		emitLdi(regR2, 16'h0080);
		prog.push_back(encode(opSt, regR1, regR2, regR0));
		expectWrite(16'h0080, value);
		addAluTest(opAdd, 16'h0081);
		addAluTest(opSub, 16'h0082);
		addAluTest(opAnd, 16'h0083);
		addAluTest(opOr, 16'h0084);
		addAluTest(opXor, 16'h0085);
		addAluTest(opMov, 16'h0086);
		presetAddr = 16'h00a0;
		presetData = 16'($random(seed));
		emitLdi(regSp, presetAddr);
		prog.push_back(encode(opLd, regR0, regSp, regR0));
		emitLdi(regLr, 16'h0090);
		prog.push_back(encode(opSt, regR0, regLr, regR0));
		expectWrite(16'h0090, presetData);
		value = 16'($random(seed));
		addJzTest(value, value, 16'h0091);
		addJzTest(value, value + 16'd1, 16'h0092);
		prog.push_back(encode(opHalt, regR0, regR0, regR0));
	endtask

	task automatic loadProgram();
		for (int i = 0; i < prog.size(); i++) begin
			i_mem.mem[8'(i)] = prog[i];
		end
		i_mem.mem[8'(presetAddr)] = presetData;
	endtask

	task automatic checkWrite();
		$display("%0t ns write %h to %h", $time, writeData, writeAddr);
		if (writeCount >= expAddr.size()) begin
			reportFailure($sformatf("unexpected write to %h", writeAddr));
		end else begin
			assert (writeAddr == expAddr[writeCount] && writeData == expData[writeCount])
				else reportFailure($sformatf("write %0d went to %h with %h, expected %h with %h",
					writeCount, writeAddr, writeData, expAddr[writeCount], expData[writeCount]));
			writeCount++;
		end
	endtask

	// bus and halt checks sampled mid-cycle
	always @(negedge clock) begin
		if (reset) begin
			assert (!wbCyc && !wbStb && !halted)
				else reportFailure("bus cycle or halted active during reset");
		end else begin
			assert (wbCyc == wbStb) else reportFailure("cyc and stb differ");
			if (prevStb && !prevAck) begin
				assert (wbStb && wbWe === prevWe && wbAdr === prevAdr && wbDatO === prevDat)
					else reportFailure("bus cycle changed before ack");
			end
			if (prevStb && prevAck) begin
				assert (!wbStb) else reportFailure("stb still high after ack");
			end
			if (prevHalted) begin
				assert (halted && !wbCyc) else reportFailure("bus cycle or halt drop after halt");
			end
			if (writeSeen) begin
				checkWrite();
			end
		end
		prevStb = wbStb;
		prevAck = wbAck;
		prevWe = wbWe;
		prevAdr = wbAdr;
		prevDat = wbDatO;
		prevHalted = halted;
	end

	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: the CPU did not halt within %0d cycles", cycleLimit);
			$display("Checks failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		reset = 1'b1;
		seed = seedValue;
		buildProgram();
		@(posedge clock);
		#2;
		loadProgram(); // cpu is held in reset
		repeat (7) @(posedge clock);
		#2;
		reset = 1'b0;
		while (!halted) begin
			@(negedge clock);
		end
		repeat (10) @(negedge clock); // bus must stay idle after halt
		if (writeCount == expAddr.size()) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("[FAIL] %0t ns %0d writes seen, expected %0d", $time, writeCount,
				expAddr.size());
			$display("Checks failed");
			$fatal(1, "missing writes");
		end
	end

endmodule

// ==== cpu.f ====
design/cpuPkg.sv
design/regSel.sv
design/registerBank.sv
design/alu.sv
design/busMaster.sv
design/mSeq.sv
design/cpu.sv
bench/wbMemory.sv
bench/cpuBench.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= cpuBench
FILELIST ?= cpu.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= All checks passed
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
